/* include/usb_crc16.svh */
`ifndef USB_CRC16_SVH
`define USB_CRC16_SVH

// One byte of USB CRC16, register kept MSB-first
// Data bits enter LSB first, as they go out on the wire
function automatic logic [15:0] usb_crc16_next(input logic [7:0] data,
                                               input logic [15:0] crc_in);
  logic [15:0] poly;
  logic [15:0] crc;
  logic        fb;
  // Normal form of the reflected polynomial (8005 hex)
  poly = {<<{CRC16_POLY}};
  crc  = crc_in;
  for (int i = 0; i < 8; i++) begin
    fb  = crc[15] ^ data[i];
    crc = {crc[14:0], 1'b0};
    if (fb) begin
      crc = crc ^ poly;
    end
  end
  return crc;
endfunction

`endif

/* hw/ulpi_tx_pkg.sv */
package ulpi_tx_pkg;

  // Encoder states
  // INIT and REGW/RWAIT serve PHY setup before high speed
  // IDLE through DONE serve USB packets
  typedef enum logic [3:0] {
    INIT,
    REGW,
    RWAIT,
    IDLE,
    XPID,
    DATA,
    CRC0,
    CRC1,
    LAST,
    DONE
  } tx_state_e;

  // Upper two bits of a ULPI TX CMD byte
  typedef enum logic [1:0] {
    CMD_TRANSMIT = 2'b01,
    CMD_REGWRITE = 2'b10
  } ulpi_cmd_e;

  // CRC16 seed, all ones
  localparam logic [15:0] CRC16_INIT = 16'hFFFF;

  // USB CRC16 polynomial in reflected form
  localparam logic [15:0] CRC16_POLY = 16'hA001;

  // Packet identifier, low nibble of a PID byte
  typedef logic [3:0] usb_pid_t;

endpackage

/* hw/ulpi_byte_if.sv */
`timescale 1ns/1ps

// One byte on its way from the encoder to the ULPI output stage
interface ulpi_byte_if;

  logic       valid;
  logic       ready;
  // Marks the stop cycle, data is zero then
  logic       last;
  logic [7:0] data;

  // Encoder side
  modport src (
    output valid,
    output last,
    output data,
    input  ready
  );

  // Output skid side
  modport dst (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

/* hw/usb_crc16_gen.sv */
`timescale 1ns/1ps

module usb_crc16_gen (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear_i,
  input  logic        update_i,
  input  logic [7:0]  data_i,
  output logic [15:0] crc_o
);

  import ulpi_tx_pkg::*;

  `include "usb_crc16.svh"

  // Running CRC, MSB-first form
  logic [15:0] crc_q;

  // Reseeded between packets
  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= CRC16_INIT;
    end else if (update_i) begin
      crc_q <= usb_crc16_next(data_i, crc_q);
    end
  end

  // Wire order is LSB first
  // Reversed and inverted, so bit 0 of the low byte leads
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc_o[i] = ~crc_q[15 - i];
    end
  end

endmodule

/* hw/ulpi_tx_ctrl.sv */
`timescale 1ns/1ps

module ulpi_tx_ctrl (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 high_speed_i,
  input  logic                 phy_write_i,
  input  logic [5:0]           phy_addr_i,
  input  logic [7:0]           phy_data_i,
  input  logic                 hsk_send_i,
  input  ulpi_tx_pkg::usb_pid_t hsk_pid_i,
  input  logic                 s_tvalid_i,
  input  logic                 s_tlast_i,
  input  logic [7:0]           s_tdata_i,
  input  ulpi_tx_pkg::usb_pid_t s_tuser_i,
  output logic                 s_tready_o,
  input  logic                 ulpi_dir_i,
  input  logic [15:0]          crc_i,
  output logic                 crc_clear_o,
  output logic                 crc_update_o,
  input  logic                 stop_done_i,
  output logic                 phy_done_o,
  output logic                 hsk_done_o,
  output logic                 usb_done_o,
  output logic                 usb_busy_o,
  ulpi_byte_if.src             byte_o
);

  import ulpi_tx_pkg::*;

  tx_state_e  state_q;
  tx_state_e  state_d;
  logic       dir_q;
  logic       hold;
  logic       xfer;
  logic       done_now;
  logic       start_reg;
  logic       start_pkt;
  // Kind of the transfer in flight
  logic       xfer_reg_q;
  logic       xfer_hsk_q;
  logic       usb_busy_q;
  logic       phy_done_q;
  logic       hsk_done_q;
  logic       usb_done_q;
  // Latched request payload
  logic [5:0] addr_q;
  logic [7:0] wdata_q;
  usb_pid_t   pid_q;

  // PHY owns the bus, plus one turnaround cycle
  assign hold      = ulpi_dir_i || dir_q;
  assign xfer      = byte_o.valid && byte_o.ready;
  assign done_now  = (state_q == DONE) && stop_done_i;
  assign start_reg = (state_q == INIT) && (state_d == REGW);
  assign start_pkt = (state_q == IDLE) && (state_d == XPID);

  // Stream only moves while payload bytes are taken
  assign s_tready_o   = byte_o.ready && high_speed_i && (state_q == DATA);
  assign crc_update_o = s_tvalid_i && s_tready_o;
  assign crc_clear_o  = (state_q == DONE);

  assign phy_done_o = phy_done_q;
  assign hsk_done_o = hsk_done_q;
  assign usb_done_o = usb_done_q;
  assign usb_busy_o = usb_busy_q;

  // Byte offered to the skid stage
  always_comb begin
    byte_o.valid = 1'b0;
    byte_o.last  = 1'b0;
    byte_o.data  = 8'h00;
    case (state_q)
      REGW: begin
        byte_o.valid = 1'b1;
        byte_o.data  = {CMD_REGWRITE, addr_q};
      end
      RWAIT: begin
        byte_o.valid = 1'b1;
        byte_o.data  = wdata_q;
      end
      XPID: begin
        byte_o.valid = 1'b1;
        byte_o.data  = {CMD_TRANSMIT, 2'b00, pid_q};
      end
      DATA: begin
        byte_o.valid = s_tvalid_i;
        byte_o.data  = s_tdata_i;
      end
      // CRC goes out low byte first
      CRC0: begin
        byte_o.valid = 1'b1;
        byte_o.data  = crc_i[7:0];
      end
      CRC1: begin
        byte_o.valid = 1'b1;
        byte_o.data  = crc_i[15:8];
      end
      // Stop cycle
      LAST: begin
        byte_o.valid = 1'b1;
        byte_o.last  = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    if (!hold) begin
      case (state_q)
        INIT:    state_d = high_speed_i ? IDLE : (phy_write_i ? REGW : INIT);
        REGW:    state_d = xfer ? RWAIT : REGW;
        RWAIT:   state_d = xfer ? LAST : RWAIT;
        // Handshake wins over stream data
        IDLE:    state_d = (hsk_send_i || s_tvalid_i) ? XPID : IDLE;
        XPID:    state_d = xfer ? (xfer_hsk_q ? LAST : DATA) : XPID;
        DATA:    state_d = (xfer && s_tlast_i) ? CRC0 : DATA;
        CRC0:    state_d = xfer ? CRC1 : CRC0;
        CRC1:    state_d = xfer ? LAST : CRC1;
        LAST:    state_d = xfer ? DONE : LAST;
        // Wait for the stop cycle to leave toward the PHY
        DONE:    state_d = stop_done_i ? (xfer_reg_q ? INIT : IDLE) : DONE;
        default: state_d = INIT;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= INIT;
      dir_q      <= 1'b0;
      xfer_reg_q <= 1'b0;
      xfer_hsk_q <= 1'b0;
      usb_busy_q <= 1'b0;
      phy_done_q <= 1'b0;
      hsk_done_q <= 1'b0;
      usb_done_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      dir_q      <= ulpi_dir_i;
      phy_done_q <= done_now && xfer_reg_q;
      hsk_done_q <= done_now && xfer_hsk_q;
      usb_done_q <= done_now && !xfer_reg_q && !xfer_hsk_q;
      if (start_reg) begin
        xfer_reg_q <= 1'b1;
      end
      if (start_pkt) begin
        xfer_reg_q <= 1'b0;
        xfer_hsk_q <= hsk_send_i;
        usb_busy_q <= 1'b1;
      end
      if (done_now) begin
        usb_busy_q <= 1'b0;
      end
    end
  end

  // Request payload, captured when the request is taken
  always_ff @(posedge clock) begin
    if (start_reg) begin
      addr_q  <= phy_addr_i;
      wdata_q <= phy_data_i;
    end
    if (start_pkt) begin
      pid_q <= hsk_send_i ? hsk_pid_i : s_tuser_i;
    end
  end

  // Only one kind of transfer ends at a time
  a_one_done: assert property (@(posedge clock) disable iff (reset)
    $onehot0({phy_done_q, hsk_done_q, usb_done_q}));

endmodule

/* hw/ulpi_out_skid.sv */
`timescale 1ns/1ps

module ulpi_out_skid (
  input  logic       clock,
  input  logic       reset,
  ulpi_byte_if.dst   byte_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_stp_o,
  output logic       stop_done_o
);

  // Head entry drives the ULPI bus
  logic       head_valid;
  logic       head_last;
  logic [7:0] head_data;
  // Overflow entry catches a byte offered as nxt drops
  logic       ovf_valid;
  logic       ovf_last;
  logic [7:0] ovf_data;
  logic       dir_q;
  logic       hold;
  logic       push;
  logic       pop;

  // Bus turnaround covers the cycle after dir too
  assign hold = ulpi_dir_i || dir_q;

  // Free while the overflow entry is empty
  assign byte_i.ready = !ovf_valid && !hold;
  assign push         = byte_i.valid && byte_i.ready;
  // Stop cycle leaves without nxt
  assign pop          = head_valid && !hold && (ulpi_nxt_i || head_last);

  assign ulpi_data_o = (head_valid && !hold) ? head_data : 8'h00;
  assign ulpi_stp_o  = head_valid && head_last && !hold;
  assign stop_done_o = pop && head_last;

  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q      <= 1'b0;
      head_valid <= 1'b0;
      ovf_valid  <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
      if (pop) begin
        // Overflow moves up, else refill straight from the source
        if (ovf_valid) begin
          head_valid <= 1'b1;
          ovf_valid  <= 1'b0;
        end else begin
          head_valid <= push;
        end
      end else if (push) begin
        if (head_valid) begin
          ovf_valid <= 1'b1;
        end else begin
          head_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pop && ovf_valid) begin
      head_last <= ovf_last;
      head_data <= ovf_data;
    end else if (push && (pop || !head_valid)) begin
      head_last <= byte_i.last;
      head_data <= byte_i.data;
    end
    // Stalled head, so park the new byte
    if (push && head_valid && !pop) begin
      ovf_last <= byte_i.last;
      ovf_data <= byte_i.data;
    end
  end

  // Overflow entry only ever sits behind a full head
  a_no_overrun: assert property (@(posedge clock) disable iff (reset)
    ovf_valid |-> head_valid);

endmodule

/* hw/ulpi_tx_top.sv */
`timescale 1ns/1ps

module ulpi_tx_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 high_speed_i,
  input  logic                 phy_write_i,
  input  logic [5:0]           phy_addr_i,
  input  logic [7:0]           phy_data_i,
  input  logic                 hsk_send_i,
  input  ulpi_tx_pkg::usb_pid_t hsk_pid_i,
  input  logic                 s_tvalid_i,
  input  logic                 s_tlast_i,
  input  logic [7:0]           s_tdata_i,
  input  ulpi_tx_pkg::usb_pid_t s_tuser_i,
  output logic                 s_tready_o,
  output logic                 phy_done_o,
  output logic                 hsk_done_o,
  output logic                 usb_done_o,
  output logic                 usb_busy_o,
  input  logic                 ulpi_dir_i,
  input  logic                 ulpi_nxt_i,
  output logic [7:0]           ulpi_data_o,
  output logic                 ulpi_stp_o
);

  logic [15:0] crc_w;
  logic        crc_clear_w;
  logic        crc_update_w;
  logic        stop_done_w;

  // Encoder to output stage
  ulpi_byte_if byte_bus ();

  ulpi_tx_ctrl ulpi_tx_ctrl_inst (
    .clock        (clock),
    .reset        (reset),
    .high_speed_i (high_speed_i),
    .phy_write_i  (phy_write_i),
    .phy_addr_i   (phy_addr_i),
    .phy_data_i   (phy_data_i),
    .hsk_send_i   (hsk_send_i),
    .hsk_pid_i    (hsk_pid_i),
    .s_tvalid_i   (s_tvalid_i),
    .s_tlast_i    (s_tlast_i),
    .s_tdata_i    (s_tdata_i),
    .s_tuser_i    (s_tuser_i),
    .s_tready_o   (s_tready_o),
    .ulpi_dir_i   (ulpi_dir_i),
    .crc_i        (crc_w),
    .crc_clear_o  (crc_clear_w),
    .crc_update_o (crc_update_w),
    .stop_done_i  (stop_done_w),
    .phy_done_o   (phy_done_o),
    .hsk_done_o   (hsk_done_o),
    .usb_done_o   (usb_done_o),
    .usb_busy_o   (usb_busy_o),
    .byte_o       (byte_bus.src)
  );

  // CRC sees the payload straight off the stream
  usb_crc16_gen usb_crc16_gen_inst (
    .clock    (clock),
    .reset    (reset),
    .clear_i  (crc_clear_w),
    .update_i (crc_update_w),
    .data_i   (s_tdata_i),
    .crc_o    (crc_w)
  );

  ulpi_out_skid ulpi_out_skid_inst (
    .clock       (clock),
    .reset       (reset),
    .byte_i      (byte_bus.dst),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_o (ulpi_data_o),
    .ulpi_stp_o  (ulpi_stp_o),
    .stop_done_o (stop_done_w)
  );

endmodule

/* dv/ulpi_tx_tb.sv */
`timescale 1ns/1ps

module ulpi_tx_tb;

  import ulpi_tx_pkg::*;

  // Seven tests, the longest about 20 bytes at three in four nxt cycles
  localparam int MAX_CYCLES = 4000;

  logic        clock;
  logic        reset;
  logic        high_speed_i;
  logic        phy_write_i;
  logic [5:0]  phy_addr_i;
  logic [7:0]  phy_data_i;
  logic        hsk_send_i;
  usb_pid_t    hsk_pid_i;
  logic        s_tvalid_i;
  logic        s_tlast_i;
  logic [7:0]  s_tdata_i;
  usb_pid_t    s_tuser_i;
  logic        s_tready_o;
  logic        phy_done_o;
  logic        hsk_done_o;
  logic        usb_done_o;
  logic        usb_busy_o;
  logic        ulpi_dir_i;
  logic        ulpi_nxt_i;
  logic [7:0]  ulpi_data_o;
  logic        ulpi_stp_o;

  integer      seed;
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  int          cycle_cnt;
  string       cur_test;
  // Bytes seen by the PHY model, and the expected sequence
  logic [7:0]  rec_q[$];
  logic [7:0]  exp_q[$];
  int          stop_cnt;
  logic        in_pkt;
  logic        dir_last;
  tx_state_e   dbg_state;

  ulpi_tx_top ulpi_tx_top_inst (.*);

  // Encoder state, only for the timeout message
  assign dbg_state = ulpi_tx_top_inst.ulpi_tx_ctrl_inst.state_q;

  always #20 clock = ~clock;

  // PHY nxt, high about three cycles in four
  always @(posedge clock) begin
    #2;
    ulpi_nxt_i = ($random(seed) % 4) != 0;
  end

  // PHY receive side
  // A byte counts when nxt is high outside the dir turnaround
  // A packet opens on its nonzero TX CMD byte
  always @(negedge clock) begin
    if (!reset && !ulpi_dir_i && !dir_last) begin
      if (ulpi_stp_o) begin
        stop_cnt++;
        in_pkt = 1'b0;
        check_byte("stop cycle data", 8'h00, ulpi_data_o);
      end else if (ulpi_nxt_i && (in_pkt || ulpi_data_o != 8'h00)) begin
        rec_q.push_back(ulpi_data_o);
        in_pkt = 1'b1;
      end
    end
    dir_last = ulpi_dir_i;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles in test %s, encoder state %s",
             MAX_CYCLES, cur_test, dbg_state.name());
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s, %s: expected %02h, actual %02h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_pid(input string what, input usb_pid_t exp, input usb_pid_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s, %s: expected PID %h, actual PID %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s, %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("Error %s, %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic begin_test(input string name);
    next_cycle();
    cur_test = name;
    err_mark = errors;
    rec_q.delete();
    exp_q.delete();
    stop_cnt = 0;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_mark) begin
      $display("Test %s: ok", cur_test);
    end else begin
      $display("Test %s: %0d errors", cur_test, errors - err_mark);
    end
  endtask

  // USB CRC16, reflected form, complemented at the end
  function automatic logic [15:0] ref_crc16(input logic [7:0] bytes[$]);
    logic [15:0] crc;
    crc = CRC16_INIT;
    foreach (bytes[i]) begin
      crc = crc ^ {8'h00, bytes[i]};
      for (int b = 0; b < 8; b++) begin
        if (crc[0]) begin
          crc = (crc >> 1) ^ CRC16_POLY;
        end else begin
          crc = crc >> 1;
        end
      end
    end
    return ~crc;
  endfunction

  // Waits for any done pulse, then checks it lasts one cycle
  task automatic wait_done(output logic phy_f, output logic hsk_f, output logic usb_f);
    phy_f = 1'b0;
    hsk_f = 1'b0;
    usb_f = 1'b0;
    while (!(phy_f || hsk_f || usb_f)) begin
      @(negedge clock);
      phy_f = phy_done_o;
      hsk_f = hsk_done_o;
      usb_f = usb_done_o;
    end
    repeat (3) begin
      @(negedge clock);
      check_flag("single done pulse", 1'b0, phy_done_o | hsk_done_o | usb_done_o);
      check_flag("busy after done", 1'b0, usb_busy_o);
    end
  endtask

  // Recorded bytes against exp_q, then exactly one stop cycle
  task automatic expect_packet();
    int n;
    check_count("bytes on ULPI", exp_q.size(), rec_q.size());
    n = (exp_q.size() < rec_q.size()) ? exp_q.size() : rec_q.size();
    for (int i = 0; i < n; i++) begin
      check_byte($sformatf("byte %0d", i), exp_q[i], rec_q[i]);
    end
    check_count("stop cycles", 1, stop_cnt);
  endtask

  // Streams random payload and fills exp_q with the whole packet
  task automatic send_packet(input int len, input usb_pid_t pid);
    logic [7:0]  payload[$];
    logic [31:0] rnd;
    logic [15:0] crc;
    logic        accepted;
    int          idx;
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      payload.push_back(rnd[7:0]);
    end
    crc = ref_crc16(payload);
    exp_q.push_back({CMD_TRANSMIT, 2'b00, pid});
    foreach (payload[i]) begin
      exp_q.push_back(payload[i]);
    end
    // Low CRC byte first
    exp_q.push_back(crc[7:0]);
    exp_q.push_back(crc[15:8]);
    idx = 0;
    s_tuser_i  = pid;
    s_tvalid_i = 1'b1;
    s_tdata_i  = payload[0];
    s_tlast_i  = (len == 1);
    while (idx < len) begin
      @(negedge clock);
      accepted = s_tvalid_i && s_tready_o;
      next_cycle();
      if (accepted) begin
        idx++;
        if (idx < len) begin
          s_tdata_i = payload[idx];
          s_tlast_i = (idx == len - 1);
        end
      end
    end
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
  endtask

  task automatic test_reset();
    begin_test("reset");
    repeat (2) begin
      @(negedge clock);
      check_flag("stp", 1'b0, ulpi_stp_o);
      check_byte("data", 8'h00, ulpi_data_o);
      check_flag("s_tready", 1'b0, s_tready_o);
      check_flag("busy", 1'b0, usb_busy_o);
      check_flag("phy_done", 1'b0, phy_done_o);
      check_flag("hsk_done", 1'b0, hsk_done_o);
      check_flag("usb_done", 1'b0, usb_done_o);
    end
    // Stream beat offered before high speed
    next_cycle();
    s_tvalid_i = 1'b1;
    s_tlast_i  = 1'b1;
    s_tdata_i  = 8'h3C;
    repeat (5) begin
      @(negedge clock);
      check_flag("s_tready before high speed", 1'b0, s_tready_o);
      check_flag("busy before high speed", 1'b0, usb_busy_o);
    end
    next_cycle();
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    check_count("bytes on ULPI", 0, rec_q.size());
    end_test();
  endtask

  task automatic test_reg_write();
    logic p;
    logic h;
    logic u;
    begin_test("register write");
    phy_write_i = 1'b1;
    phy_addr_i  = 6'h16;
    phy_data_i  = 8'hA5;
    next_cycle();
    phy_write_i = 1'b0;
    wait_done(p, h, u);
    exp_q.push_back({CMD_REGWRITE, 6'h16});
    exp_q.push_back(8'hA5);
    check_flag("phy_done", 1'b1, p);
    check_flag("hsk_done", 1'b0, h);
    check_flag("usb_done", 1'b0, u);
    expect_packet();
    end_test();
  endtask

  task automatic test_handshake();
    logic p;
    logic h;
    logic u;
    begin_test("handshake");
    high_speed_i = 1'b1;
    next_cycle();
    hsk_send_i = 1'b1;
    hsk_pid_i  = 4'h2;
    while (!usb_busy_o) begin
      @(negedge clock);
    end
    next_cycle();
    hsk_send_i = 1'b0;
    wait_done(p, h, u);
    exp_q.push_back({CMD_TRANSMIT, 2'b00, 4'h2});
    check_flag("phy_done", 1'b0, p);
    check_flag("hsk_done", 1'b1, h);
    check_flag("usb_done", 1'b0, u);
    expect_packet();
    if (rec_q.size() > 0) begin
      check_pid("PID in TX CMD", 4'h2, rec_q[0][3:0]);
    end
    end_test();
  endtask

  task automatic test_data_packet(input int len, input usb_pid_t pid);
    logic p;
    logic h;
    logic u;
    begin_test($sformatf("data packet of %0d bytes", len));
    send_packet(len, pid);
    wait_done(p, h, u);
    check_flag("phy_done", 1'b0, p);
    check_flag("hsk_done", 1'b0, h);
    check_flag("usb_done", 1'b1, u);
    expect_packet();
    if (rec_q.size() > 0) begin
      check_pid("PID in TX CMD", pid, rec_q[0][3:0]);
    end
    end_test();
  endtask

  task automatic test_dir_freeze();
    logic p;
    logic h;
    logic u;
    begin_test("dir freeze");
    fork
      send_packet(16, 4'hB);
      begin
        // PHY takes the bus once the packet is under way
        while (rec_q.size() < 3) begin
          @(negedge clock);
        end
        next_cycle();
        ulpi_dir_i = 1'b1;
        repeat (6) begin
          @(negedge clock);
          check_byte("data while dir", 8'h00, ulpi_data_o);
          check_flag("stp while dir", 1'b0, ulpi_stp_o);
        end
        next_cycle();
        ulpi_dir_i = 1'b0;
        // Turnaround cycle is still masked
        @(negedge clock);
        check_byte("data in turnaround", 8'h00, ulpi_data_o);
        check_flag("stp in turnaround", 1'b0, ulpi_stp_o);
      end
    join
    wait_done(p, h, u);
    check_flag("usb_done", 1'b1, u);
    expect_packet();
    end_test();
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    high_speed_i = 1'b0;
    phy_write_i  = 1'b0;
    phy_addr_i   = 6'h00;
    phy_data_i   = 8'h00;
    hsk_send_i   = 1'b0;
    hsk_pid_i    = 4'h0;
    s_tvalid_i   = 1'b0;
    s_tlast_i    = 1'b0;
    s_tdata_i    = 8'h00;
    s_tuser_i    = 4'h0;
    ulpi_dir_i   = 1'b0;
    ulpi_nxt_i   = 1'b0;
    seed         = 10069;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    stop_cnt     = 0;
    in_pkt       = 1'b0;
    dir_last     = 1'b0;
    cur_test     = "startup";
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;
    test_reset();
    test_reg_write();
    test_handshake();
    test_data_packet(1, 4'h3);
    test_data_packet(5, 4'hB);
    test_data_packet(16, 4'h3);
    test_dir_freeze();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
hw/ulpi_tx_pkg.sv
hw/ulpi_byte_if.sv
hw/usb_crc16_gen.sv
hw/ulpi_tx_ctrl.sv
hw/ulpi_out_skid.sv
hw/ulpi_tx_top.sv
dv/ulpi_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ULPI transmit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ulpi_tx_tb \
  -f list.f \
  -o ulpi_tx_sim

./obj_dir/ulpi_tx_sim | tee sim.log

if grep -q -F -x "*** PASSED ***" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail, see sim.log"
  exit 1
fi
